/* mips_alu.sv */
`default_nettype none

module mips_alu (
    input  mips_pkg::alu_op_e           op,
    input  logic [mips_pkg::data_w-1:0] a,
    input  logic [mips_pkg::data_w-1:0] b,
    input  logic [4:0]                  shamt,
    output logic [mips_pkg::data_w-1:0] result,
    output logic                        equal
);

    logic signed [mips_pkg::data_w-1:0] a_s;
    logic signed [mips_pkg::data_w-1:0] b_s;

    assign a_s = a;
    assign b_s = b;

    always_comb begin
        case (op)
            mips_pkg::alu_and: begin
                result = a & b;
            end
            mips_pkg::alu_or: begin
                result = a | b;
            end
            mips_pkg::alu_add: begin
                result = a + b;     // also lw/sw address
            end
            mips_pkg::alu_sub: begin
                result = a - b;
            end
            mips_pkg::alu_slt: begin
                result = (a_s < b_s) ? 32'd1 : 32'd0;
            end
            mips_pkg::alu_sll: begin
                result = b << shamt;    // rt is the shifted operand
            end
            mips_pkg::alu_srl: begin
                result = b >> shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // branch compare, independent of op
    assign equal = (a == b);

endmodule

`default_nettype wire

/* mips_core.sv */
`default_nettype none

module mips_core (
    input  logic                            clk,
    input  logic                            rst_n,
    output logic [mips_pkg::data_w-1:0]     ir_addr,
    input  logic [mips_pkg::data_w-1:0]     ir,
    input  logic [mips_pkg::data_w-1:0]     read_data_mem,
    output logic                            cen,
    output logic                            wen,
    output logic                            oen,
    output logic [mips_pkg::mem_addr_w-1:0] a,
    output logic [mips_pkg::data_w-1:0]     data_to_mem
);

    // instruction fields
    logic [mips_pkg::reg_addr_w-1:0] rs;
    logic [mips_pkg::reg_addr_w-1:0] rt;
    logic [mips_pkg::reg_addr_w-1:0] rd;
    logic [4:0]                      shamt;
    logic [mips_pkg::data_w-1:0]     imm_ext;

    // control from the decoder
    logic              reg_dst;
    logic              alu_src;
    logic              reg_write;
    logic              mem_to_reg;
    logic              mem_read;
    logic              mem_write;
    logic              branch_eq;
    logic              branch_ne;
    logic              jump;
    logic              jump_reg;
    logic              link;
    mips_pkg::alu_op_e alu_op;

    logic [mips_pkg::data_w-1:0]     rs_data;
    logic [mips_pkg::data_w-1:0]     rt_data;
    logic [mips_pkg::data_w-1:0]     alu_b;
    logic [mips_pkg::data_w-1:0]     alu_result;
    logic                            equal;
    logic                            branch_taken;
    logic [mips_pkg::data_w-1:0]     pc_plus4;
    logic [mips_pkg::reg_addr_w-1:0] wr_addr;
    logic [mips_pkg::data_w-1:0]     wr_data;

    assign rs      = ir[25:21];
    assign rt      = ir[20:16];
    assign rd      = ir[15:11];
    assign shamt   = ir[10:6];
    assign imm_ext = {{16{ir[15]}}, ir[15:0]};

    mips_decoder i_decoder (
        .opcode     (mips_pkg::opcode_e'(ir[31:26])),
        .funct      (mips_pkg::funct_e'(ir[5:0])),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .reg_write  (reg_write),
        .mem_to_reg (mem_to_reg),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .branch_eq  (branch_eq),
        .branch_ne  (branch_ne),
        .jump       (jump),
        .jump_reg   (jump_reg),
        .link       (link),
        .alu_op     (alu_op)
    );

    // jal overrides the normal rd/rt choice
    assign wr_addr = link    ? mips_pkg::reg_ra :
                     reg_dst ? rd : rt;

    assign wr_data = link       ? pc_plus4 :
                     mem_to_reg ? read_data_mem : alu_result;

    mips_regfile i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs),
        .rt_addr (rt),
        .wr_addr (wr_addr),
        .wr_en   (reg_write),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    assign alu_b = alu_src ? imm_ext : rt_data;

    mips_alu i_alu (
        .op     (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (shamt),
        .result (alu_result),
        .equal  (equal)
    );

    assign branch_taken = (branch_eq & equal) | (branch_ne & ~equal);

    mips_pc i_pc (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_taken  (branch_taken),
        .jump          (jump),
        .jump_reg      (jump_reg),
        .jump_index    (ir[25:0]),
        .branch_offset (imm_ext),
        .jr_target     (rs_data),
        .pc            (ir_addr),
        .pc_plus4      (pc_plus4)
    );

    // memory port, all levels active low, idle during reset
    assign cen = ~((mem_read | mem_write) & rst_n);
    assign wen = ~(mem_write & rst_n);
    assign oen = ~(mem_read & rst_n);

    assign a           = alu_result[8:2];  // word address
    assign data_to_mem = rt_data;

endmodule

`default_nettype wire

/* mips_decoder.sv */
`default_nettype none

module mips_decoder (
    input  mips_pkg::opcode_e opcode,
    input  mips_pkg::funct_e  funct,
    output logic              reg_dst,
    output logic              alu_src,
    output logic              reg_write,
    output logic              mem_to_reg,
    output logic              mem_read,
    output logic              mem_write,
    output logic              branch_eq,
    output logic              branch_ne,
    output logic              jump,
    output logic              jump_reg,
    output logic              link,
    output mips_pkg::alu_op_e alu_op
);

    always_comb begin
        // everything inactive unless a known code turns it on
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch_eq  = 1'b0;
        branch_ne  = 1'b0;
        jump       = 1'b0;
        jump_reg   = 1'b0;
        link       = 1'b0;
        alu_op     = mips_pkg::alu_add;

        case (opcode)
            mips_pkg::op_rtype: begin
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    mips_pkg::fn_add: alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_sub: alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and: alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:  alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt: alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_sll: alu_op = mips_pkg::alu_sll;
                    mips_pkg::fn_srl: alu_op = mips_pkg::alu_srl;
                    mips_pkg::fn_jr: begin
                        reg_write = 1'b0;
                        jump_reg  = 1'b1;   // target comes from rs
                    end
                    default: begin
                        reg_dst   = 1'b0;   // unknown funct is a no-op
                        reg_write = 1'b0;
                    end
                endcase
            end
            mips_pkg::op_addi: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::op_lw: begin
                alu_src    = 1'b1;      // base + offset
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                mem_read   = 1'b1;
            end
            mips_pkg::op_sw: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            mips_pkg::op_beq: begin
                branch_eq = 1'b1;
                alu_op    = mips_pkg::alu_sub;
            end
            mips_pkg::op_bne: begin
                branch_ne = 1'b1;
                alu_op    = mips_pkg::alu_sub;
            end
            mips_pkg::op_j: jump = 1'b1;
            mips_pkg::op_jal: begin
                jump      = 1'b1;
                link      = 1'b1;       // pc+4 into $ra
                reg_write = 1'b1;
            end
            default: ;                  // no-op
        endcase
    end

    // the memory port can only do one thing per instruction
    always_comb begin
        assert (!(mem_read && mem_write))
            else $error("decoder asserts mem_read and mem_write together");
    end

endmodule

`default_nettype wire

/* mips_pc.sv */
`default_nettype none

module mips_pc (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        branch_taken,
    input  logic                        jump,
    input  logic                        jump_reg,
    input  logic [25:0]                 jump_index,
    input  logic [mips_pkg::data_w-1:0] branch_offset,
    input  logic [mips_pkg::data_w-1:0] jr_target,
    output logic [mips_pkg::data_w-1:0] pc,
    output logic [mips_pkg::data_w-1:0] pc_plus4
);

    logic [mips_pkg::data_w-1:0] jump_target;
    logic [mips_pkg::data_w-1:0] branch_target;
    logic [mips_pkg::data_w-1:0] pc_next;

    assign pc_plus4 = pc + 32'd4;

    // region bits kept from the sequential address
    assign jump_target = {pc_plus4[mips_pkg::data_w-1:mips_pkg::data_w-4], jump_index, 2'b00};

    assign branch_target = pc_plus4 + {branch_offset[mips_pkg::data_w-3:0], 2'b00};

    always_comb begin
        if (jump_reg) begin
            pc_next = jr_target;
        end else if (jump) begin
            pc_next = jump_target;
        end else if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // jr takes its target from a register, so alignment depends on software
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    ) else $error("pc left word alignment: %h", pc);

endmodule

`default_nettype wire

/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // datapath geometry
    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int mem_addr_w = 7;   // 128-word data memory

    localparam logic [reg_addr_w-1:0] reg_ra = 5'd31;  // jal link register

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    // funct field of r-type, bits 5:0
    typedef enum logic [5:0] {
        fn_sll = 6'h00,
        fn_srl = 6'h02,
        fn_jr  = 6'h08,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    // alu operation select
    typedef enum logic [3:0] {
        alu_and = 4'b0000,
        alu_or  = 4'b0001,
        alu_add = 4'b0010,
        alu_sll = 4'b0011,
        alu_srl = 4'b0100,
        alu_sub = 4'b0110,
        alu_slt = 4'b0111
    } alu_op_e;

endpackage

`default_nettype wire

/* mips_regfile.sv */
`default_nettype none

module mips_regfile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [mips_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_pkg::reg_addr_w-1:0] rt_addr,
    input  logic [mips_pkg::reg_addr_w-1:0] wr_addr,
    input  logic                            wr_en,
    input  logic [mips_pkg::data_w-1:0]     wr_data,
    output logic [mips_pkg::data_w-1:0]     rs_data,
    output logic [mips_pkg::data_w-1:0]     rt_data
);

    logic [mips_pkg::data_w-1:0] regs [mips_pkg::num_regs];

    // $zero is hardwired
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mips_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;   // writes to $zero dropped
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it; exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mips_core -f tb.f -o sim_tb &&
./obj_dir/sim_tb || {
    echo "simulation failed"
    exit 1
}

/* tb.f */
mips_pkg.sv
mips_decoder.sv
mips_pc.sv
mips_regfile.sv
mips_alu.sv
mips_core.sv
tb_mips_core.sv

/* tb_mips_core.sv */
`default_nettype none

module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 5;
    localparam int max_cycles   = 250;  // ~200 straight-line slots plus the subroutine calls
    localparam int body_end     = 188;  // first slot after the random body
    localparam int final_slot   = 192;  // j to itself
    localparam int sub_slot     = 196;  // jal target

    logic        clk;
    logic        rst_n;
    logic [31:0] ir_addr;
    logic [31:0] ir;
    logic [31:0] read_data_mem;
    logic        cen;
    logic        wen;
    logic        oen;
    logic [6:0]  a;
    logic [31:0] data_to_mem;

    logic [31:0] imem [256];
    logic [31:0] dmem [128];

    // reference model state
    logic [31:0] mregs [32];
    logic [31:0] mdmem [128];
    logic [31:0] mpc;
    logic [31:0] rng;

    mips_core i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .ir_addr       (ir_addr),
        .ir            (ir),
        .read_data_mem (read_data_mem),
        .cen           (cen),
        .wen           (wen),
        .oen           (oen),
        .a             (a),
        .data_to_mem   (data_to_mem)
    );

    assign ir            = imem[ir_addr[9:2]];
    assign read_data_mem = dmem[a];     // same-cycle read

    always @(posedge clk) begin
        if (!cen && !wen) begin
            dmem[a] <= data_to_mem;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // upper lcg bits are the better ones
    function automatic int unsigned pick(input int unsigned n);
        rng = lcg_next(rng);
        return {16'h0, rng[31:16]} % n;
    endfunction

    function automatic logic [31:0] fill_word(input int unsigned addr);
        return 32'hc3a5_0000 ^ (addr * 32'h0001_0203);
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic build_program();
        int unsigned idx;
        int unsigned kind;
        int unsigned last_word;
        logic [4:0]  r_s;
        logic [4:0]  r_t;
        logic [4:0]  r_d;
        logic [5:0]  fn;
        last_word = 0;
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)] = 32'h0;
        end
        // r1..r15 get signed immediates first
        for (idx = 0; idx < 15; idx++) begin
            imem[8'(idx)] = enc_i(mips_pkg::op_addi, 5'(idx + 1), 5'd0, 16'(pick(65536)));
        end
        while (idx < body_end) begin
            r_s  = 5'(pick(16));
            r_t  = 5'(pick(16));
            r_d  = 5'(pick(16));     // rd of 0 hits the hardwired zero
            kind = pick(16);
            if (idx % 50 == 25) begin
                imem[8'(idx)] = enc_j(mips_pkg::op_jal, 26'(sub_slot));
            end else if (kind < 6) begin
                case (pick(7))
                    0:       fn = mips_pkg::fn_add;
                    1:       fn = mips_pkg::fn_sub;
                    2:       fn = mips_pkg::fn_and;
                    3:       fn = mips_pkg::fn_or;
                    4:       fn = mips_pkg::fn_slt;
                    5:       fn = mips_pkg::fn_sll;
                    default: fn = mips_pkg::fn_srl;
                endcase
                if (fn == mips_pkg::fn_sll || fn == mips_pkg::fn_srl) begin
                    imem[8'(idx)] = enc_r(fn, r_d, 5'd0, r_t, 5'(pick(32)));
                end else begin
                    imem[8'(idx)] = enc_r(fn, r_d, r_s, r_t, 5'd0);
                end
            end else if (kind < 9) begin
                imem[8'(idx)] = enc_i(mips_pkg::op_addi, 5'(pick(15) + 1), r_s, 16'(pick(65536)));
            end else if (kind < 11) begin
                last_word = pick(128);
                if (pick(8) == 0) begin
                    r_t = 5'd31;
                end
                imem[8'(idx)] = enc_i(mips_pkg::op_sw, r_t, 5'd0, 16'(last_word * 4));
            end else if (kind < 13) begin
                // reload the most recent store address
                imem[8'(idx)] = enc_i(mips_pkg::op_lw, 5'(pick(15) + 1), 5'd0, 16'(last_word * 4));
            end else if (kind < 15) begin
                if (pick(2) == 0) begin
                    r_t = r_s;
                end
                imem[8'(idx)] = enc_i(pick(2) != 0 ? mips_pkg::op_beq : mips_pkg::op_bne,
                                      r_t, r_s, 16'(pick(3) + 1));
            end else begin
                imem[8'(idx)] = enc_j(mips_pkg::op_j, 26'(idx + 2 + pick(2)));
            end
            idx++;
        end
        for (idx = body_end; idx < final_slot; idx++) begin
            imem[8'(idx)] = enc_i(mips_pkg::op_addi, 5'(idx - body_end + 1), 5'd0, 16'(idx));
        end
        imem[8'(final_slot)]   = enc_j(mips_pkg::op_j, 26'(final_slot));
        // subroutine saves the link register, then returns
        imem[8'(sub_slot)]     = enc_i(mips_pkg::op_sw, 5'd31, 5'd0, 16'd508);
        imem[8'(sub_slot + 1)] = enc_i(mips_pkg::op_addi, 5'd10, 5'd10, 16'd3);
        imem[8'(sub_slot + 2)] = enc_r(mips_pkg::fn_jr, 5'd0, 5'd31, 5'd0, 5'd0);
    endtask

    // one instruction of the architecture, as the processor should execute it
    function automatic void mips_step(
        input  logic [31:0] regs [32],
        input  logic [31:0] mem [128],
        input  logic [31:0] pc,
        input  logic [31:0] instr,
        output logic [31:0] next_pc,
        output logic        e_cen,
        output logic        e_wen,
        output logic        e_oen,
        output logic [6:0]  e_addr,
        output logic [31:0] e_store,
        output logic        we,
        output logic [4:0]  wa,
        output logic [31:0] wd
    );
        logic [31:0] rs_v;
        logic [31:0] rt_v;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] pc4;
        rs_v    = regs[instr[25:21]];
        rt_v    = regs[instr[20:16]];
        imm     = {{16{instr[15]}}, instr[15:0]};
        addr    = rs_v + imm;
        pc4     = pc + 32'd4;
        next_pc = pc4;
        e_cen   = 1'b1;
        e_wen   = 1'b1;
        e_oen   = 1'b1;
        e_addr  = addr[8:2];
        e_store = rt_v;
        we      = 1'b0;
        wa      = instr[20:16];
        wd      = 32'h0;
        case (instr[31:26])
            mips_pkg::op_rtype: begin
                we = 1'b1;
                wa = instr[15:11];
                case (instr[5:0])
                    mips_pkg::fn_add: wd = rs_v + rt_v;
                    mips_pkg::fn_sub: wd = rs_v - rt_v;
                    mips_pkg::fn_and: wd = rs_v & rt_v;
                    mips_pkg::fn_or:  wd = rs_v | rt_v;
                    mips_pkg::fn_slt: wd = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
                    mips_pkg::fn_sll: wd = rt_v << instr[10:6];
                    mips_pkg::fn_srl: wd = rt_v >> instr[10:6];
                    mips_pkg::fn_jr: begin
                        we      = 1'b0;
                        next_pc = rs_v;
                    end
                    default: we = 1'b0;     // unknown funct, no-op
                endcase
            end
            mips_pkg::op_addi: begin
                we = 1'b1;
                wd = addr;
            end
            mips_pkg::op_lw: begin
                e_cen = 1'b0;
                e_oen = 1'b0;
                we    = 1'b1;
                wd    = mem[addr[8:2]];
            end
            mips_pkg::op_sw: begin
                e_cen = 1'b0;
                e_wen = 1'b0;
            end
            mips_pkg::op_beq: begin
                if (rs_v == rt_v) begin
                    next_pc = pc4 + {imm[29:0], 2'b00};
                end
            end
            mips_pkg::op_bne: begin
                if (rs_v != rt_v) begin
                    next_pc = pc4 + {imm[29:0], 2'b00};
                end
            end
            mips_pkg::op_j: next_pc = {pc4[31:28], instr[25:0], 2'b00};
            mips_pkg::op_jal: begin
                next_pc = {pc4[31:28], instr[25:0], 2'b00};
                we      = 1'b1;
                wa      = 5'd31;
                wd      = pc4;
            end
            default: ;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        logic [31:0] boot_word;
        rng   = 32'h90a82cc8;
        rst_n = 1'b0;
        build_program();
        for (int i = 0; i < 128; i++) begin
            dmem[7'(i)] = fill_word(i);
        end
        boot_word = imem[0];
        // slot 0 holds sw and lw in turn while reset keeps the port idle
        for (int i = 0; i < reset_cycles; i++) begin
            if (i % 2 == 0) begin
                imem[0] = enc_i(mips_pkg::op_sw, 5'd1, 5'd0, 16'd0);
            end else begin
                imem[0] = enc_i(mips_pkg::op_lw, 5'd1, 5'd0, 16'd0);
            end
            @(posedge clk);
            #1;
        end
        imem[0] = boot_word;
        rst_n   = 1'b1;
    end

    // compare at the falling edge, mid-cycle
    initial begin : compare_proc
        logic [31:0] next_pc;
        logic        e_cen;
        logic        e_wen;
        logic        e_oen;
        logic [6:0]  e_addr;
        logic [31:0] e_store;
        logic        we;
        logic [4:0]  wa;
        logic [31:0] wd;
        logic        done;
        for (int i = 0; i < 32; i++) begin
            mregs[5'(i)] = 32'h0;
        end
        for (int i = 0; i < 128; i++) begin
            mdmem[7'(i)] = fill_word(i);
        end
        mpc  = 32'h0;
        done = 1'b0;
        @(negedge clk);
        while (!rst_n) begin
            check_value("cen/wen/oen in reset", 32'({cen, wen, oen}), 32'h7);
            check_value("ir_addr in reset", ir_addr, 32'h0);
            @(negedge clk);
        end
        while (!done) begin
            mips_step(mregs, mdmem, mpc, imem[mpc[9:2]], next_pc, e_cen, e_wen, e_oen,
                      e_addr, e_store, we, wa, wd);
            check_value("ir_addr", ir_addr, mpc);
            check_value("cen/wen/oen", 32'({cen, wen, oen}), 32'({e_cen, e_wen, e_oen}));
            if (!e_cen) begin
                check_value("a", 32'(a), 32'(e_addr));
            end
            if (!e_wen) begin
                check_value("data_to_mem", data_to_mem, e_store);
                mdmem[e_addr] = e_store;
            end
            if (we && wa != 5'd0) begin
                mregs[wa] = wd;     // $zero keeps its value
            end
            if (next_pc == mpc) begin
                done = 1'b1;
            end else begin
                mpc = next_pc;
                @(negedge clk);
            end
        end
        @(negedge clk);
        check_value("ir_addr on final self-jump", ir_addr, mpc);
        for (int i = 0; i < 128; i++) begin
            check_value($sformatf("dmem[%0d]", i), dmem[7'(i)], mdmem[7'(i)]);
        end
        $display("RESULT: PASS");
        $finish;
    end

    initial begin : watchdog
        repeat (reset_cycles + max_cycles) @(posedge clk);
        $display("ERROR: the program did not reach its final self-jump within %0d cycles",
                 max_cycles);
        $display("RESULT: FAIL");
        $fatal(1);
    end

endmodule

`default_nettype wire
